//--- Bender.yml
package:
  name: eeprom_array

sources:
  - files:
      - hw/eeprom_pkg.sv
      - hw/eeprom_chan_if.sv
      - hw/eeprom_dispatch.sv
      - hw/eeprom_bus_ctrl.sv
      - hw/eeprom_collect.sv
      - hw/eeprom_array_top.sv
  - target: test
    files:
      - bench/eeprom_model.sv
      - bench/eeprom_checker.sv
      - bench/eeprom_tb.sv

//--- bench/eeprom_checker.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_checker
#(
    parameter int ABSENT_CHAN = 3
)
(
    input  wire                               CLK,
    input  wire                               RESET,
    input  wire                               wr,
    input  wire                               rd,
    input  wire [eeprom_pkg::HADDR_W-1:0]     addr,
    input  wire [eeprom_pkg::DATA_W-1:0]      wdata,
    input  wire [eeprom_pkg::N_CHAN-1:0]      chan_busy,
    input  wire                               rsp_valid,
    input  wire [eeprom_pkg::CHAN_W-1:0]      rsp_chan,
    input  wire                               rsp_nack,
    input  wire [eeprom_pkg::DATA_W-1:0]      rsp_rdata,
    input  wire [eeprom_pkg::N_CHAN-1:0]      scl,
    input  wire [eeprom_pkg::N_CHAN-1:0]      sda,
    output int                                errors,
    output int                                outstanding
);

    logic [7:0] mirror [eeprom_pkg::N_CHAN][2**eeprom_pkg::WADDR_W];
    logic [9:0] exp_q [eeprom_pkg::N_CHAN][$];    // {is_rd, nack, rdata}
    logic [eeprom_pkg::N_CHAN-1:0] issued;
    logic [eeprom_pkg::N_CHAN-1:0] busy_prev;
    logic [eeprom_pkg::N_CHAN-1:0] busy_fell;    // completed, response still due
    logic                          idle_seen;

    always @(posedge CLK)
    begin
        int                             ch;
        logic [eeprom_pkg::WADDR_W-1:0] wa;
        logic [9:0]                     e;
        if (RESET)
        begin
            errors      = 0;
            outstanding = 0;
            idle_seen   = 1'b0;
            issued      = '0;
            busy_prev   = '0;
            busy_fell   = '0;
            for (int c = 0; c < eeprom_pkg::N_CHAN; c++)
            begin
                exp_q[c].delete();
                for (int a = 0; a < 2**eeprom_pkg::WADDR_W; a++)
                    mirror[c][a] = 8'(a) ^ 8'(c * 16) ^ 8'(a >> 8);
            end
        end
        else
        begin
            if (!idle_seen)
            begin
                idle_seen = 1'b1;
                if (rsp_valid !== 1'b0 || chan_busy !== '0 || scl !== '1 || sda !== '1)
                begin
                    $display("t=%0t outputs or bus lines not idle after reset", $time);
                    errors++;
                end
            end

            for (int c = 0; c < eeprom_pkg::N_CHAN; c++)
            begin
                if (issued[c] && chan_busy[c] !== 1'b1)
                begin
                    $display("FAIL t=%0t chan_busy[%0d] expected 1 got %b", $time, c, chan_busy[c]);
                    errors++;
                end
                if (chan_busy[c] && !busy_prev[c] && !issued[c])
                begin
                    $display("t=%0t chan_busy[%0d] rose with no command", $time, c);
                    errors++;
                end
                if (!chan_busy[c] && busy_prev[c])
                    busy_fell[c] = 1'b1;
            end
            busy_prev = chan_busy;
            issued    = '0;

            if (wr || rd)
            begin
                ch = int'(addr[eeprom_pkg::HADDR_W-1 -: eeprom_pkg::CHAN_W]);
                wa = addr[eeprom_pkg::WADDR_W-1:0];
                e  = {rd, (ch == ABSENT_CHAN), (ch == ABSENT_CHAN) ? 8'hff : mirror[ch][wa]};
                if (wr && ch != ABSENT_CHAN)
                    mirror[ch][wa] = wdata;
                exp_q[ch].push_back(e);
                issued[ch] = 1'b1;
            end

            if (rsp_valid)
            begin
                ch = int'(rsp_chan);
                if (exp_q[ch].size() == 0)
                begin
                    $display("t=%0t unexpected response arrived on channel %0d", $time, ch);
                    errors++;
                end
                else
                begin
                    e = exp_q[ch].pop_front();
                    if (!busy_fell[ch])
                    begin
                        $display("t=%0t response on channel %0d before chan_busy fell", $time, ch);
                        errors++;
                    end
                    busy_fell[ch] = 1'b0;
                    if (rsp_nack !== e[8])
                    begin
                        $display("FAIL t=%0t rsp_nack ch%0d expected %b got %b",
                                 $time, ch, e[8], rsp_nack);
                        errors++;
                    end
                    if (e[9] && rsp_rdata !== e[7:0])
                    begin
                        $display("FAIL t=%0t rsp_rdata ch%0d expected %h got %h",
                                 $time, ch, e[7:0], rsp_rdata);
                        errors++;
                    end
                end
            end

            outstanding = 0;
            for (int c = 0; c < eeprom_pkg::N_CHAN; c++)
                outstanding += exp_q[c].size();
        end
    end

endmodule

`default_nettype wire

//--- bench/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model
#(
    parameter int CHAN    = 0,
    parameter bit PRESENT = 1'b1
)
(
    input  wire scl,
    inout  wire sda
);

    logic [7:0] mem [2**eeprom_pkg::WADDR_W];
    logic       drive_low = 1'b0;
    logic       active = 1'b0;
    logic       ack = 1'b0;
    logic       rd_mode = 1'b0;
    logic       tx_byte = 1'b0;    // device sends this byte
    int         bits = 0;
    int         byte_idx = 0;
    logic [7:0] sh;
    logic [2:0] blk;
    logic [7:0] lo;
    logic [7:0] rbyte;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int a = 0; a < 2**eeprom_pkg::WADDR_W; a++)
            mem[a] = 8'(a) ^ 8'(CHAN * 16) ^ 8'(a >> 8);
    end

    // control, address, then data byte of a write
    task automatic take_byte();
        ack = 1'b1;
        case (byte_idx)
            0:
            begin
                blk     = sh[3:1];
                rd_mode = sh[0];
                ack     = (sh[7:4] == eeprom_pkg::DEV_CODE);
                rbyte   = mem[{sh[3:1], lo}];
            end
            1:
                lo = sh;
            default:
                mem[{blk, lo}] = sh;
        endcase
        byte_idx = byte_idx + 1;
        if (!ack)
            active = 1'b0;
    endtask

    always @(negedge sda)
    begin
        if (scl === 1'b1 && PRESENT)    // start or repeated start
        begin
            active    = 1'b1;
            bits      = 0;
            byte_idx  = 0;
            rd_mode   = 1'b0;
            tx_byte   = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)    // stop
        begin
            active    = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            bits = bits + 1;
            if (bits <= 8 && !tx_byte)
                sh = {sh[6:0], (sda !== 1'b0)};
            if (bits == 8 && !tx_byte)
                take_byte();
            if (bits == 9 && tx_byte && sda !== 1'b0)
                active = 1'b0;    // master nack ends the read
        end
    end

    // sda only moves while scl is low
    always @(negedge scl)
    begin
        if (active)
        begin
            #1;
            if (bits == 8)
                drive_low = !tx_byte && ack;
            else if (bits == 9)
            begin
                bits      = 0;
                tx_byte   = rd_mode;
                drive_low = rd_mode && !rbyte[7];
            end
            else if (tx_byte && bits > 0)
                drive_low = !rbyte[7 - bits];
        end
    end

endmodule

`default_nettype wire

//--- bench/eeprom_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_tb;

    localparam int N_CMDS      = 300;
    localparam int ABSENT_CHAN = 3;
    // longest transaction is under 160 cycles of 20 ns
    localparam int WATCHDOG_NS = N_CMDS * 160 * 20 + 20000;

    logic                               CLK;
    logic                               RESET;
    logic                               wr;
    logic                               rd;
    logic [eeprom_pkg::HADDR_W-1:0]     addr;
    logic [eeprom_pkg::DATA_W-1:0]      wdata;
    wire  [eeprom_pkg::N_CHAN-1:0]      chan_busy;
    wire                                rsp_valid;
    wire  [eeprom_pkg::CHAN_W-1:0]      rsp_chan;
    wire                                rsp_nack;
    wire  [eeprom_pkg::DATA_W-1:0]      rsp_rdata;
    wire  [eeprom_pkg::N_CHAN-1:0]      scl;
    wire  [eeprom_pkg::N_CHAN-1:0]      sda;
    int                                 seed = 96;
    int                                 errors;
    int                                 outstanding;
    int                                 bench_errors = 0;

    eeprom_array_top dut_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .chan_busy (chan_busy),
        .rsp_valid (rsp_valid),
        .rsp_chan  (rsp_chan),
        .rsp_nack  (rsp_nack),
        .rsp_rdata (rsp_rdata),
        .scl       (scl),
        .sda       (sda)
    );

    for (genvar g = 0; g < eeprom_pkg::N_CHAN; g++)
    begin : g_dev
        pullup (sda[g]);
        eeprom_model #(.CHAN(g), .PRESENT(g != ABSENT_CHAN)) model_i
        (
            .scl (scl[g]),
            .sda (sda[g])
        );
    end

    eeprom_checker #(.ABSENT_CHAN(ABSENT_CHAN)) check_i
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .chan_busy   (chan_busy),
        .rsp_valid   (rsp_valid),
        .rsp_chan    (rsp_chan),
        .rsp_nack    (rsp_nack),
        .rsp_rdata   (rsp_rdata),
        .scl         (scl),
        .sda         (sda),
        .errors      (errors),
        .outstanding (outstanding)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // 16 word addresses per channel, spread over the whole device
    task automatic issue_random();
        logic [eeprom_pkg::CHAN_W-1:0]  ch;
        logic [3:0]                     idx;
        logic                           is_rd;
        ch    = eeprom_pkg::CHAN_W'($random(seed));
        idx   = 4'($random(seed));
        is_rd = 1'($random(seed));
        @(negedge CLK);
        while (chan_busy[ch])
            @(negedge CLK);
        @(posedge CLK);
        wr    <= !is_rd;
        rd    <= is_rd;
        addr  <= {ch, eeprom_pkg::WADDR_W'(idx * 131)};
        wdata <= eeprom_pkg::DATA_W'($random(seed));
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    initial
    begin
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        RESET = 1'b1;
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        repeat (2) @(posedge CLK);

        for (int n = 0; n < N_CMDS; n++)
            issue_random();

        // drain the last responses
        @(negedge CLK);
        for (int w = 0; w < 400 && outstanding != 0; w++)
            @(negedge CLK);
        if (outstanding != 0)
        begin
            $display("%0d responses went missing", outstanding);
            bench_errors++;
        end

        $display("errors: checker %0d, bench %0d", errors, bench_errors);
        if (errors == 0 && bench_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/eeprom_array_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_array_top
(
    input  wire                                CLK,
    input  wire                                RESET,
    input  wire                                wr,
    input  wire                                rd,
    input  wire  [eeprom_pkg::HADDR_W-1:0]     addr,
    input  wire  [eeprom_pkg::DATA_W-1:0]      wdata,
    output logic [eeprom_pkg::N_CHAN-1:0]      chan_busy,
    output logic                               rsp_valid,
    output logic [eeprom_pkg::CHAN_W-1:0]      rsp_chan,
    output logic                               rsp_nack,
    output logic [eeprom_pkg::DATA_W-1:0]      rsp_rdata,
    output logic [eeprom_pkg::N_CHAN-1:0]      scl,
    inout  wire  [eeprom_pkg::N_CHAN-1:0]      sda
);

    eeprom_chan_if chan_bus [eeprom_pkg::N_CHAN] ();

    eeprom_dispatch dispatch_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .chan      (chan_bus),
        .chan_busy (chan_busy)
    );

    // one bus sequencer per device
    for (genvar g = 0; g < eeprom_pkg::N_CHAN; g++)
    begin : g_ctrl
        eeprom_bus_ctrl ctrl_i
        (
            .CLK   (CLK),
            .RESET (RESET),
            .cmd   (chan_bus[g]),
            .scl   (scl[g]),
            .sda   (sda[g])
        );
    end

    eeprom_collect collect_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .chan      (chan_bus),
        .rsp_valid (rsp_valid),
        .rsp_chan  (rsp_chan),
        .rsp_nack  (rsp_nack),
        .rsp_rdata (rsp_rdata)
    );

endmodule

`default_nettype wire

//--- hw/eeprom_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_bus_ctrl
(
    input  wire         CLK,
    input  wire         RESET,
    eeprom_chan_if.ctrl cmd,
    output logic        scl,
    inout  wire         sda
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_WDATA,
        ST_RESTART,
        ST_CTRL_R,
        ST_DATA_R,
        ST_STOP,
        ST_DONE
    } state_t;

    state_t                         state;
    logic [eeprom_pkg::PH_W-1:0]    ph;
    logic [eeprom_pkg::BCNT_W-1:0]  bit_cnt;
    logic                           sda_low;    // 1 pulls the line low
    logic                           nack_r;
    logic                           is_rd;
    logic [eeprom_pkg::WADDR_W-1:0] addr_r;
    logic [eeprom_pkg::DATA_W-1:0]  wdata_r;
    logic [eeprom_pkg::DATA_W-1:0]  shift_r;
    logic [eeprom_pkg::DATA_W-1:0]  next_byte;
    logic                           load_byte;
    logic                           start_cmd;
    logic                           bit_end;
    logic                           byte_end;
    logic                           in_tx;
    logic                           in_byte;

    assign start_cmd = (state == ST_IDLE) && (cmd.wr || cmd.rd);
    assign bit_end   = (ph == eeprom_pkg::PH_LAST);
    assign byte_end  = bit_end && (bit_cnt == eeprom_pkg::ACK_BIT);
    assign in_tx     = (state == ST_CTRL_W) || (state == ST_ADDR) ||
                       (state == ST_WDATA) || (state == ST_CTRL_R);
    assign in_byte   = in_tx || (state == ST_DATA_R);

    // idle bus parks scl high
    assign scl = (state == ST_IDLE || state == ST_DONE) ? 1'b1 : (ph >= eeprom_pkg::PH_SAMPLE);
    assign sda = sda_low ? 1'b0 : 1'bz;

    assign cmd.busy  = (state != ST_IDLE && state != ST_DONE) || cmd.wr || cmd.rd;
    assign cmd.done  = (state == ST_DONE);
    assign cmd.nack  = nack_r;
    assign cmd.rdata = shift_r;

    // next byte for the shifter at each byte boundary
    always_comb
    begin
        load_byte = 1'b0;
        next_byte = wdata_r;
        case (state)
            ST_START:
            begin
                load_byte = bit_end;
                next_byte = {eeprom_pkg::DEV_CODE, addr_r[eeprom_pkg::WADDR_W-1:eeprom_pkg::DATA_W],
                             eeprom_pkg::RW_WRITE};
            end
            ST_CTRL_W:
            begin
                load_byte = byte_end;
                next_byte = addr_r[eeprom_pkg::DATA_W-1:0];
            end
            ST_ADDR:
                load_byte = byte_end && !is_rd;
            ST_RESTART:
            begin
                load_byte = bit_end;
                next_byte = {eeprom_pkg::DEV_CODE, addr_r[eeprom_pkg::WADDR_W-1:eeprom_pkg::DATA_W],
                             eeprom_pkg::RW_READ};
            end
            default:
                load_byte = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ST_IDLE;
            ph      <= '0;
            bit_cnt <= '0;
            sda_low <= 1'b0;
            nack_r  <= 1'b0;
            is_rd   <= 1'b0;
        end
        else
        begin
            if (state != ST_IDLE && state != ST_DONE)
                ph <= bit_end ? '0 : ph + 1'b1;

            if (in_byte && bit_end)
                bit_cnt <= byte_end ? '0 : bit_cnt + 1'b1;

            // sda moves in the low half, never while scl rises
            case (state)
                ST_START, ST_RESTART:
                    if (ph == '0)
                        sda_low <= 1'b0;
                    else if (ph == eeprom_pkg::PH_SAMPLE)
                        sda_low <= 1'b1;    // falls with scl high
                ST_STOP:
                    if (ph == '0)
                        sda_low <= 1'b1;
                    else if (ph == eeprom_pkg::PH_SAMPLE)
                        sda_low <= 1'b0;    // rises with scl high
                ST_CTRL_W, ST_ADDR, ST_WDATA, ST_CTRL_R:
                    if (ph == '0)
                        sda_low <= (bit_cnt != eeprom_pkg::ACK_BIT) &&
                                   !shift_r[eeprom_pkg::DATA_W-1];
                default:
                    sda_low <= 1'b0;    // read bits and master nack
            endcase

            if (in_tx && ph == eeprom_pkg::PH_SAMPLE && bit_cnt == eeprom_pkg::ACK_BIT)
                nack_r <= nack_r | sda;

            case (state)
                ST_IDLE:
                    if (start_cmd)
                    begin
                        state  <= ST_START;
                        is_rd  <= cmd.rd;
                        nack_r <= 1'b0;
                    end
                ST_START:   if (bit_end) state <= ST_CTRL_W;
                ST_CTRL_W:  if (byte_end) state <= ST_ADDR;
                ST_ADDR:    if (byte_end) state <= is_rd ? ST_RESTART : ST_WDATA;
                ST_WDATA:   if (byte_end) state <= ST_STOP;
                ST_RESTART: if (bit_end) state <= ST_CTRL_R;
                ST_CTRL_R:  if (byte_end) state <= ST_DATA_R;
                ST_DATA_R:  if (byte_end) state <= ST_STOP;
                ST_STOP:    if (bit_end) state <= ST_DONE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start_cmd)
        begin
            addr_r  <= cmd.addr;
            wdata_r <= cmd.wdata;
        end

        if (load_byte)
            shift_r <= next_byte;
        else if (in_tx && bit_end && bit_cnt != eeprom_pkg::ACK_BIT)
            shift_r <= shift_r << 1;    // msb first
        else if (state == ST_DATA_R && ph == eeprom_pkg::PH_SAMPLE &&
                 bit_cnt != eeprom_pkg::ACK_BIT)
            shift_r <= {shift_r[eeprom_pkg::DATA_W-2:0], sda};
    end

endmodule

`default_nettype wire

//--- hw/eeprom_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface eeprom_chan_if;

    logic                           wr;
    logic                           rd;
    logic [eeprom_pkg::WADDR_W-1:0] addr;
    logic [eeprom_pkg::DATA_W-1:0]  wdata;
    logic                           busy;
    logic                           done;
    logic                           nack;
    logic [eeprom_pkg::DATA_W-1:0]  rdata;

    modport disp (output wr, rd, addr, wdata, input busy);
    modport ctrl (input wr, rd, addr, wdata, output busy, done, nack, rdata);
    modport coll (input done, nack, rdata);

endinterface

`default_nettype wire

//--- hw/eeprom_collect.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_collect
(
    input  wire                                CLK,
    input  wire                                RESET,
    eeprom_chan_if.coll                        chan [eeprom_pkg::N_CHAN],
    output logic                               rsp_valid,
    output logic [eeprom_pkg::CHAN_W-1:0]      rsp_chan,
    output logic                               rsp_nack,
    output logic [eeprom_pkg::DATA_W-1:0]      rsp_rdata
);

    logic [eeprom_pkg::N_CHAN-1:0] done_v;
    logic [eeprom_pkg::N_CHAN-1:0] nack_v;
    logic [eeprom_pkg::DATA_W-1:0] rdata_v [eeprom_pkg::N_CHAN];
    logic [eeprom_pkg::N_CHAN-1:0] pend;
    logic [eeprom_pkg::N_CHAN-1:0] nack_p;
    logic [eeprom_pkg::DATA_W-1:0] rdata_p [eeprom_pkg::N_CHAN];
    logic [eeprom_pkg::CHAN_W-1:0] ptr;
    logic [eeprom_pkg::CHAN_W-1:0] pick;

    for (genvar g = 0; g < eeprom_pkg::N_CHAN; g++)
    begin : g_chan
        assign done_v[g]  = chan[g].done;
        assign nack_v[g]  = chan[g].nack;
        assign rdata_v[g] = chan[g].rdata;
    end

    // first pending at or after ptr, lowest offset wins
    always_comb
    begin
        logic [eeprom_pkg::CHAN_W-1:0] idx;
        rsp_valid = 1'b0;
        pick      = ptr;
        for (int k = eeprom_pkg::N_CHAN - 1; k >= 0; k--)
        begin
            idx = ptr + k[eeprom_pkg::CHAN_W-1:0];
            if (pend[idx])
            begin
                rsp_valid = 1'b1;
                pick      = idx;
            end
        end
    end

    assign rsp_chan  = pick;
    assign rsp_nack  = nack_p[pick];
    assign rsp_rdata = rdata_p[pick];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pend <= '0;
            ptr  <= '0;
        end
        else
        begin
            for (int i = 0; i < eeprom_pkg::N_CHAN; i++)
            begin
                if (done_v[i])
                    pend[i] <= 1'b1;
                else if (rsp_valid && int'(pick) == i)
                    pend[i] <= 1'b0;
            end
            if (rsp_valid)
                ptr <= pick + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < eeprom_pkg::N_CHAN; i++)
        begin
            if (done_v[i])
            begin
                nack_p[i]  <= nack_v[i];
                rdata_p[i] <= rdata_v[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/eeprom_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_dispatch
(
    input  wire                                CLK,
    input  wire                                RESET,
    input  wire                                wr,
    input  wire                                rd,
    input  wire  [eeprom_pkg::HADDR_W-1:0]     addr,
    input  wire  [eeprom_pkg::DATA_W-1:0]      wdata,
    eeprom_chan_if.disp                        chan [eeprom_pkg::N_CHAN],
    output logic [eeprom_pkg::N_CHAN-1:0]      chan_busy
);

    logic [eeprom_pkg::CHAN_W-1:0]  sel;
    logic [eeprom_pkg::N_CHAN-1:0]  wr_q;
    logic [eeprom_pkg::N_CHAN-1:0]  rd_q;
    logic [eeprom_pkg::WADDR_W-1:0] addr_q;
    logic [eeprom_pkg::DATA_W-1:0]  wdata_q;

    assign sel = addr[eeprom_pkg::HADDR_W-1 -: eeprom_pkg::CHAN_W];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_q <= '0;
            rd_q <= '0;
        end
        else
        begin
            for (int i = 0; i < eeprom_pkg::N_CHAN; i++)
            begin
                wr_q[i] <= wr && (int'(sel) == i);
                rd_q[i] <= rd && (int'(sel) == i);
            end
        end
    end

    // payload rides along with the strobe
    always_ff @(posedge CLK)
    begin
        if (wr || rd)
        begin
            addr_q  <= addr[eeprom_pkg::WADDR_W-1:0];
            wdata_q <= wdata;
        end
    end

    for (genvar g = 0; g < eeprom_pkg::N_CHAN; g++)
    begin : g_chan
        assign chan[g].wr    = wr_q[g];
        assign chan[g].rd    = rd_q[g];
        assign chan[g].addr  = addr_q;
        assign chan[g].wdata = wdata_q;
        assign chan_busy[g]  = chan[g].busy;
    end

endmodule

`default_nettype wire

//--- hw/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int N_CHAN  = 4;
    localparam int CHAN_W  = 2;     // channel select, top of host address
    localparam int WADDR_W = 11;    // 2 KB device
    localparam int HADDR_W = 13;
    localparam int DATA_W  = 8;

    // scl period in CLK cycles, one quarter per cycle
    localparam int CLK_PER_BIT = 4;
    localparam int PH_W        = $clog2(CLK_PER_BIT);

    // first high quarter, where sda is sampled
    localparam logic [PH_W-1:0] PH_SAMPLE = PH_W'(CLK_PER_BIT / 2);
    localparam logic [PH_W-1:0] PH_LAST   = PH_W'(CLK_PER_BIT - 1);

    // bit counter covers eight data bits plus the ack slot
    localparam int BCNT_W = $clog2(DATA_W + 1);
    localparam logic [BCNT_W-1:0] ACK_BIT = BCNT_W'(DATA_W);

    localparam logic [3:0] DEV_CODE = 4'b1010;
    localparam logic       RW_WRITE = 1'b0;
    localparam logic       RW_READ  = 1'b1;

endpackage

`default_nettype wire

//--- sources.f
hw/eeprom_pkg.sv
hw/eeprom_chan_if.sv
hw/eeprom_dispatch.sv
hw/eeprom_bus_ctrl.sv
hw/eeprom_collect.sv
hw/eeprom_array_top.sv
bench/eeprom_model.sv
bench/eeprom_checker.sv
bench/eeprom_tb.sv
